//--- source/pcie_bridge_pkg.sv
/* Shared widths, BAR table types and enums for the PCIe to AXI4-Lite
   write bridge */

package pcie_bridge_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  // One AXI word per write
  parameter int addr_w = 32;
  parameter int data_w = 32;
  parameter int strb_w = data_w / 8;

  // BAR 6 and 7 are not real BARs
  parameter int num_bars = 6;

  // ----------------------------------------
  // BAR table types
  // ----------------------------------------
  // AXI base address of each BAR window
  typedef logic [63:0] bar_base_t [num_bars];

  // log2 of each BAR window size
  typedef int bar_size_t [num_bars];

  // ----------------------------------------
  // Enums
  // ----------------------------------------
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_aw   = 2'd1,
    st_w    = 2'd2,
    st_b    = 2'd3
  } wr_state_e;

  // Encoding as on the AXI B channel
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } axi_resp_e;

endpackage

//--- source/mem_wr_if.sv
/* Accepted write request, from the intake to the BAR translator */

interface mem_wr_if;

  // One-cycle request pulse
  logic                                valid;
  logic [2:0]                          bar_hit;
  logic [pcie_bridge_pkg::addr_w-1:0]  pcie_address;
  logic [pcie_bridge_pkg::strb_w-1:0]  byte_enable;
  logic [pcie_bridge_pkg::data_w-1:0]  write_data;

  // One-cycle pulse, transaction finished or dropped
  logic                                done;

  modport src (
    output valid, bar_hit, pcie_address, byte_enable, write_data,
    input  done
  );

  modport dst (
    input  valid, bar_hit, pcie_address, byte_enable, write_data,
    output done
  );

endinterface

//--- source/axi_wr_if.sv
/* Translated write from the BAR translator to the AXI write master,
   with the completion back */

interface axi_wr_if;

  logic                                valid;
  logic [pcie_bridge_pkg::addr_w-1:0]  awaddr;
  logic [pcie_bridge_pkg::data_w-1:0]  wdata;
  logic [pcie_bridge_pkg::strb_w-1:0]  wstrb;

  // Pulses on the B handshake
  logic                                done;
  logic                                slv_err;

  modport src (
    output valid, awaddr, wdata, wstrb,
    input  done, slv_err
  );

  modport dst (
    input  valid, awaddr, wdata, wstrb,
    output done, slv_err
  );

endinterface

//--- source/mem_req_intake.sv
/* Request intake: accepts PCIe memory requests, registers writes,
   discards reads and drives requester back-pressure */

module mem_req_intake (
  input  logic                                m_axi_aclk,
  input  logic                                rst_n,
  input  logic                                mem_req_valid,
  output logic                                mem_req_ready,
  input  logic [2:0]                          mem_req_bar_hit,
  input  logic [pcie_bridge_pkg::addr_w-1:0]  mem_req_pcie_address,
  input  logic [pcie_bridge_pkg::strb_w-1:0]  mem_req_byte_enable,
  input  logic                                mem_req_write_readn,
  input  logic [pcie_bridge_pkg::data_w-1:0]  mem_req_write_data,
  mem_wr_if.src                               req
);

  logic busy;
  logic wr_accept;

  // Reads handshake like writes but go no further
  assign wr_accept = mem_req_valid && mem_req_ready && mem_req_write_readn;

  // One write in flight at a time
  assign mem_req_ready = !busy;

  always_ff @(posedge m_axi_aclk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      req.valid <= 1'b0;
    end else begin
      req.valid <= wr_accept;
      if (wr_accept) begin
        busy <= 1'b1;
      end else if (req.done) begin
        busy <= 1'b0;
      end
    end
  end

  // Request fields, held until the next accepted write
  always_ff @(posedge m_axi_aclk) begin
    if (wr_accept) begin
      req.bar_hit      <= mem_req_bar_hit;
      req.pcie_address <= mem_req_pcie_address;
      req.byte_enable  <= mem_req_byte_enable;
      req.write_data   <= mem_req_write_data;
    end
  end

endmodule

//--- source/bar_addr_translate.sv
/* BAR translation: rebases the PCIe address into the AXI window of
   the hit BAR and drops writes to BAR index 6 and 7 */

module bar_addr_translate #(
  parameter pcie_bridge_pkg::bar_base_t bar_axi = '{default: 64'h0},
  parameter pcie_bridge_pkg::bar_size_t bar_size = '{default: 12}
) (
  input  logic   m_axi_aclk,
  input  logic   rst_n,
  mem_wr_if.dst  req,
  axi_wr_if.src  wr
);

  localparam int aw = pcie_bridge_pkg::addr_w;

  logic [aw-1:0] base_sel;
  logic [aw-1:0] mask_sel;
  logic [aw-1:0] mapped_addr;
  logic          bar_valid;
  logic          miss_q;

  // ----------------------------------------
  // Window select
  // ----------------------------------------
  always_comb begin
    base_sel  = '0;
    mask_sel  = '0;
    bar_valid = 1'b0;
    for (int i = 0; i < pcie_bridge_pkg::num_bars; i++) begin
      if (int'(req.bar_hit) == i) begin
        base_sel  = bar_axi[i][aw-1:0];
        // Offset bits below the BAR size
        mask_sel  = ~({aw{1'b1}} << bar_size[i]);
        bar_valid = 1'b1;
      end
    end
  end

  // Base above the window, PCIe offset inside it, word aligned
  assign mapped_addr = ((base_sel & ~mask_sel) | (req.pcie_address & mask_sel))
                       & {{(aw-2){1'b1}}, 2'b00};

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge m_axi_aclk) begin
    if (!rst_n) begin
      wr.valid <= 1'b0;
      miss_q   <= 1'b0;
    end else begin
      wr.valid <= req.valid && bar_valid;
      miss_q   <= req.valid && !bar_valid;
    end
  end

  always_ff @(posedge m_axi_aclk) begin
    if (req.valid && bar_valid) begin
      wr.awaddr <= mapped_addr;
      wr.wdata  <= req.write_data;
      wr.wstrb  <= req.byte_enable;
    end
  end

  // A dropped write completes on its own, one cycle later
  assign req.done = miss_q || wr.done;

endmodule

//--- source/axi_write_master.sv
/* AXI4-Lite write master: single outstanding write sequenced as AW,
   then W, then B */

module axi_write_master (
  input  logic                                m_axi_aclk,
  input  logic                                rst_n,
  axi_wr_if.dst                               wr,
  output logic [pcie_bridge_pkg::addr_w-1:0]  m_axi_awaddr,
  output logic [2:0]                          m_axi_awprot,
  output logic                                m_axi_awvalid,
  input  logic                                m_axi_awready,
  output logic [pcie_bridge_pkg::data_w-1:0]  m_axi_wdata,
  output logic [pcie_bridge_pkg::strb_w-1:0]  m_axi_wstrb,
  output logic                                m_axi_wvalid,
  input  logic                                m_axi_wready,
  input  logic [1:0]                          m_axi_bresp,
  input  logic                                m_axi_bvalid,
  output logic                                m_axi_bready
);

  pcie_bridge_pkg::wr_state_e state;
  pcie_bridge_pkg::axi_resp_e bresp_code;

  logic [pcie_bridge_pkg::addr_w-1:0] awaddr_q;
  logic [pcie_bridge_pkg::data_w-1:0] wdata_q;
  logic [pcie_bridge_pkg::strb_w-1:0] wstrb_q;
  logic                               start;

  // New write offered while idle, AW goes out the same cycle
  assign start = (state == pcie_bridge_pkg::st_idle) && wr.valid;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_ff @(posedge m_axi_aclk) begin
    if (!rst_n) begin
      state <= pcie_bridge_pkg::st_idle;
    end else begin
      case (state)
        pcie_bridge_pkg::st_idle:
          if (wr.valid) begin
            state <= m_axi_awready ? pcie_bridge_pkg::st_w : pcie_bridge_pkg::st_aw;
          end
        pcie_bridge_pkg::st_aw:
          if (m_axi_awready) state <= pcie_bridge_pkg::st_w;
        pcie_bridge_pkg::st_w:
          if (m_axi_wready) state <= pcie_bridge_pkg::st_b;
        pcie_bridge_pkg::st_b:
          if (m_axi_bvalid) state <= pcie_bridge_pkg::st_idle;
        default:
          state <= pcie_bridge_pkg::st_idle;
      endcase
    end
  end

  // Write payload, held for the whole transaction
  always_ff @(posedge m_axi_aclk) begin
    if (start) begin
      awaddr_q <= wr.awaddr;
      wdata_q  <= wr.wdata;
      wstrb_q  <= wr.wstrb;
    end
  end

  // ----------------------------------------
  // AXI outputs
  // ----------------------------------------
  assign m_axi_awvalid = start || (state == pcie_bridge_pkg::st_aw);
  assign m_axi_awaddr  = start ? wr.awaddr : awaddr_q;
  assign m_axi_awprot  = 3'b000;

  assign m_axi_wvalid = (state == pcie_bridge_pkg::st_w);
  assign m_axi_wdata  = wdata_q;
  assign m_axi_wstrb  = wstrb_q;

  // Responses are always taken
  assign m_axi_bready = 1'b1;

  // Completion on the B handshake
  assign bresp_code = pcie_bridge_pkg::axi_resp_e'(m_axi_bresp);
  assign wr.done    = (state == pcie_bridge_pkg::st_b) && m_axi_bvalid;
  assign wr.slv_err = wr.done && (bresp_code != pcie_bridge_pkg::resp_okay);

endmodule

//--- source/pcie_axi_wr_bridge.sv
/* Top level of the PCIe to AXI4-Lite write bridge: intake, BAR
   translation and AXI write master */

module pcie_axi_wr_bridge #(
  parameter pcie_bridge_pkg::bar_base_t bar_axi = '{
    64'h0000_0000_4000_0000,
    64'h0000_0000_4010_0000,
    64'h0000_0000_5000_0000,
    64'h0000_0000_6000_0000,
    64'h0000_0000_7000_0000,
    64'h0000_0000_8000_0000
  },
  parameter pcie_bridge_pkg::bar_size_t bar_size = '{12, 16, 20, 12, 14, 24}
) (
  input  logic                                m_axi_aclk,
  input  logic                                rst_n,

  // AXI4-Lite write master
  output logic [pcie_bridge_pkg::addr_w-1:0]  m_axi_awaddr,
  output logic [2:0]                          m_axi_awprot,
  output logic                                m_axi_awvalid,
  input  logic                                m_axi_awready,
  output logic [pcie_bridge_pkg::data_w-1:0]  m_axi_wdata,
  output logic [pcie_bridge_pkg::strb_w-1:0]  m_axi_wstrb,
  output logic                                m_axi_wvalid,
  input  logic                                m_axi_wready,
  input  logic [1:0]                          m_axi_bresp,
  input  logic                                m_axi_bvalid,
  output logic                                m_axi_bready,

  // Decoded PCIe memory request
  input  logic                                mem_req_valid,
  output logic                                mem_req_ready,
  input  logic [2:0]                          mem_req_bar_hit,
  input  logic [pcie_bridge_pkg::addr_w-1:0]  mem_req_pcie_address,
  input  logic [pcie_bridge_pkg::strb_w-1:0]  mem_req_byte_enable,
  input  logic                                mem_req_write_readn,
  // Function number is not decoded by this bridge
  input  logic                                mem_req_phys_func,
  input  logic [pcie_bridge_pkg::data_w-1:0]  mem_req_write_data,

  // Pulses on a non-OKAY write response
  output logic                                wr_err
);

  mem_wr_if mem_wr ();
  axi_wr_if axi_wr ();

  mem_req_intake mem_req_intake_inst (
    .m_axi_aclk           (m_axi_aclk),
    .rst_n                (rst_n),
    .mem_req_valid        (mem_req_valid),
    .mem_req_ready        (mem_req_ready),
    .mem_req_bar_hit      (mem_req_bar_hit),
    .mem_req_pcie_address (mem_req_pcie_address),
    .mem_req_byte_enable  (mem_req_byte_enable),
    .mem_req_write_readn  (mem_req_write_readn),
    .mem_req_write_data   (mem_req_write_data),
    .req                  (mem_wr)
  );

  bar_addr_translate #(
    .bar_axi  (bar_axi),
    .bar_size (bar_size)
  ) bar_addr_translate_inst (
    .m_axi_aclk (m_axi_aclk),
    .rst_n      (rst_n),
    .req        (mem_wr),
    .wr         (axi_wr)
  );

  axi_write_master axi_write_master_inst (
    .m_axi_aclk    (m_axi_aclk),
    .rst_n         (rst_n),
    .wr            (axi_wr),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awprot  (m_axi_awprot),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bresp   (m_axi_bresp),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready)
  );

  assign wr_err = axi_wr.slv_err;

endmodule

//--- tests/pcie_axi_wr_bridge_checker.sv
/* Concurrent assertions on the AXI write and request ports, bound to the bridge */

module pcie_axi_wr_bridge_checker (
  input logic                               m_axi_aclk,
  input logic                               rst_n,
  input logic [pcie_bridge_pkg::addr_w-1:0] m_axi_awaddr,
  input logic [2:0]                         m_axi_awprot,
  input logic                               m_axi_awvalid,
  input logic                               m_axi_awready,
  input logic [pcie_bridge_pkg::data_w-1:0] m_axi_wdata,
  input logic [pcie_bridge_pkg::strb_w-1:0] m_axi_wstrb,
  input logic                               m_axi_wvalid,
  input logic                               m_axi_wready,
  input logic                               m_axi_bready,
  input logic                               mem_req_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  // Stalled channels hold their payload
  aw_stable: assert property (@(posedge m_axi_aclk) disable iff (!rst_n)
    m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
    else $error("AW changed while stalled");

  w_stable: assert property (@(posedge m_axi_aclk) disable iff (!rst_n)
    m_axi_wvalid && !m_axi_wready |=>
      m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wstrb))
    else $error("W changed while stalled");

  aw_w_exclusive: assert property (@(posedge m_axi_aclk) disable iff (!rst_n)
    !(m_axi_awvalid && m_axi_wvalid))
    else $error("AW and W valid together");

  awaddr_aligned: assert property (@(posedge m_axi_aclk) disable iff (!rst_n)
    m_axi_awvalid |-> m_axi_awaddr[1:0] == 2'b00)
    else $error("awaddr not word aligned");

  busy_while_writing: assert property (@(posedge m_axi_aclk) disable iff (!rst_n)
    m_axi_awvalid || m_axi_wvalid |-> !mem_req_ready)
    else $error("request ready during a write");

  fixed_outputs: assert property (@(posedge m_axi_aclk) disable iff (!rst_n)
    m_axi_bready && m_axi_awprot == 3'b000)
    else $error("bready or awprot not constant");

endmodule

bind pcie_axi_wr_bridge pcie_axi_wr_bridge_checker checker_inst (
  .m_axi_aclk    (m_axi_aclk),
  .rst_n         (rst_n),
  .m_axi_awaddr  (m_axi_awaddr),
  .m_axi_awprot  (m_axi_awprot),
  .m_axi_awvalid (m_axi_awvalid),
  .m_axi_awready (m_axi_awready),
  .m_axi_wdata   (m_axi_wdata),
  .m_axi_wstrb   (m_axi_wstrb),
  .m_axi_wvalid  (m_axi_wvalid),
  .m_axi_wready  (m_axi_wready),
  .m_axi_bready  (m_axi_bready),
  .mem_req_ready (mem_req_ready)
);

//--- tests/pcie_axi_wr_bridge_tb.sv
/* Testbench for the PCIe to AXI4-Lite write bridge: request driver, AXI slave
   model, reference address mapping, compare process and watchdog */

module pcie_axi_wr_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 8;
  // 24 mapping, 16 back-pressure, 3 dropped, 3 response writes
  localparam int num_reqs = 46;

  // Bases carry stray bits below the window size on purpose
  localparam pcie_bridge_pkg::bar_base_t bar_axi = '{
    64'h0000_0000_4000_0a5c, 64'h0000_0000_4010_1234, 64'h0000_0000_5008_0000,
    64'h0000_0000_6000_0fff, 64'h0000_0000_7000_3000, 64'h0000_0000_8012_3456
  };
  localparam pcie_bridge_pkg::bar_size_t bar_size = '{12, 16, 20, 12, 14, 24};

  logic                               m_axi_aclk = 1'b0;
  logic                               rst_n;
  logic [pcie_bridge_pkg::addr_w-1:0] m_axi_awaddr;
  logic [2:0]                         m_axi_awprot;
  logic                               m_axi_awvalid;
  logic                               m_axi_awready;
  logic [pcie_bridge_pkg::data_w-1:0] m_axi_wdata;
  logic [pcie_bridge_pkg::strb_w-1:0] m_axi_wstrb;
  logic                               m_axi_wvalid;
  logic                               m_axi_wready;
  logic [1:0]                         m_axi_bresp;
  logic                               m_axi_bvalid;
  logic                               m_axi_bready;
  logic                               mem_req_valid;
  logic                               mem_req_ready;
  logic [2:0]                         mem_req_bar_hit;
  logic [pcie_bridge_pkg::addr_w-1:0] mem_req_pcie_address;
  logic [pcie_bridge_pkg::strb_w-1:0] mem_req_byte_enable;
  logic                               mem_req_write_readn;
  logic                               mem_req_phys_func;
  logic [pcie_bridge_pkg::data_w-1:0] mem_req_write_data;
  logic                               wr_err;

  // Expected writes, in issue order
  logic [pcie_bridge_pkg::addr_w-1:0] exp_addr_q[$];
  logic [pcie_bridge_pkg::data_w-1:0] exp_data_q[$];
  logic [pcie_bridge_pkg::strb_w-1:0] exp_strb_q[$];
  pcie_bridge_pkg::axi_resp_e         exp_resp_q[$];

  int errors = 0;
  int checks = 0;
  int num_tests = 0;
  int test_start = 0;
  int aw_count = 0;
  int w_count = 0;
  int max_stall = 0;
  int aw_before;
  int w_before;

  pcie_axi_wr_bridge #(
    .bar_axi  (bar_axi),
    .bar_size (bar_size)
  ) pcie_axi_wr_bridge_inst (.*);

  always #(clk_period / 2) m_axi_aclk = ~m_axi_aclk;

  // ----------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------
  // Window base from the BAR, offset from the PCIe address, word aligned
  function automatic logic [pcie_bridge_pkg::addr_w-1:0] expected_awaddr(
    input int bar, input logic [pcie_bridge_pkg::addr_w-1:0] pcie_addr);
    logic [63:0] win;
    logic [63:0] sum;
    win = 64'd1 << bar_size[bar];
    sum = (bar_axi[bar] - (bar_axi[bar] % win)) + ({32'd0, pcie_addr} % win);
    sum = sum & ~64'd3;
    return sum[pcie_bridge_pkg::addr_w-1:0];
  endfunction

  task automatic check_aw(input logic [pcie_bridge_pkg::addr_w-1:0] got,
                          input logic [pcie_bridge_pkg::addr_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: awaddr %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_w(input logic [pcie_bridge_pkg::data_w-1:0] got_data,
                         input logic [pcie_bridge_pkg::strb_w-1:0] got_strb,
                         input logic [pcie_bridge_pkg::data_w-1:0] exp_data,
                         input logic [pcie_bridge_pkg::strb_w-1:0] exp_strb);
    checks++;
    if (got_data !== exp_data || got_strb !== exp_strb) begin
      errors++;
      $display("FAIL %0t: wdata %h wstrb %h, expected %h %h", $time, got_data, got_strb,
               exp_data, exp_strb);
    end
  endtask

  task automatic check_err(input logic got, input pcie_bridge_pkg::axi_resp_e resp);
    checks++;
    if (got !== (resp != pcie_bridge_pkg::resp_okay)) begin
      errors++;
      $display("FAIL %0t: wr_err %b for response %s", $time, got, resp.name());
    end
  endtask

  task automatic report_unexpected(input string channel);
    errors++;
    $display("ERROR at %0t: %s handshake seen with no write outstanding", $time, channel);
  endtask

  // Sampled mid-cycle, one handshake per channel per cycle
  always @(negedge m_axi_aclk) begin
    if (rst_n) begin
      if (m_axi_awvalid && m_axi_awready) begin
        aw_count++;
        if (exp_addr_q.size() == 0) report_unexpected("AW");
        else check_aw(m_axi_awaddr, exp_addr_q.pop_front());
      end
      if (m_axi_wvalid && m_axi_wready) begin
        w_count++;
        if (exp_data_q.size() == 0) report_unexpected("W");
        else check_w(m_axi_wdata, m_axi_wstrb, exp_data_q.pop_front(), exp_strb_q.pop_front());
      end
      if (m_axi_bvalid && m_axi_bready) begin
        if (exp_resp_q.size() == 0) report_unexpected("B");
        else check_err(wr_err, exp_resp_q.pop_front());
      end else begin
        check_err(wr_err, pcie_bridge_pkg::resp_okay);
      end
    end
  end

  // ----------------------------------------
  // AXI slave model
  // ----------------------------------------
  task automatic stall_cycles();
    repeat ($urandom_range(max_stall, 0)) @(posedge m_axi_aclk);
  endtask

  initial begin
    forever begin
      @(negedge m_axi_aclk);
      while (!m_axi_awvalid) @(negedge m_axi_aclk);
      stall_cycles();
      @(posedge m_axi_aclk) m_axi_awready <= 1'b1;
      @(posedge m_axi_aclk) m_axi_awready <= 1'b0;
      @(negedge m_axi_aclk);
      while (!m_axi_wvalid) @(negedge m_axi_aclk);
      stall_cycles();
      @(posedge m_axi_aclk) m_axi_wready <= 1'b1;
      @(posedge m_axi_aclk) m_axi_wready <= 1'b0;
      stall_cycles();
      @(posedge m_axi_aclk);
      m_axi_bvalid <= 1'b1;
      m_axi_bresp  <= (exp_resp_q.size() != 0) ? exp_resp_q[0] : pcie_bridge_pkg::resp_okay;
      @(posedge m_axi_aclk) m_axi_bvalid <= 1'b0;
    end
  end

  // ----------------------------------------
  // Request driver
  // ----------------------------------------
  task automatic drive_req(input logic [2:0] bar, input logic [31:0] addr,
                           input logic [3:0] be, input logic wrn, input logic [31:0] data);
    @(negedge m_axi_aclk);
    while (!mem_req_ready) @(negedge m_axi_aclk);
    @(posedge m_axi_aclk);
    mem_req_valid        <= 1'b1;
    mem_req_bar_hit      <= bar;
    mem_req_pcie_address <= addr;
    mem_req_byte_enable  <= be;
    mem_req_write_readn  <= wrn;
    mem_req_phys_func    <= 1'($urandom);
    mem_req_write_data   <= data;
    @(posedge m_axi_aclk) mem_req_valid <= 1'b0;
  endtask

  task automatic send_write(input int bar, input pcie_bridge_pkg::axi_resp_e resp);
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    addr = $urandom;
    data = $urandom;
    be   = 4'($urandom);
    if (bar < pcie_bridge_pkg::num_bars) begin
      exp_addr_q.push_back(expected_awaddr(bar, addr));
      exp_data_q.push_back(data);
      exp_strb_q.push_back(be);
      exp_resp_q.push_back(resp);
    end
    drive_req(3'(bar), addr, be, 1'b1, data);
  endtask

  task automatic finish_test(input string name);
    @(negedge m_axi_aclk);
    while (exp_resp_q.size() != 0 || !mem_req_ready) @(negedge m_axi_aclk);
    num_tests++;
    $display("test %s done with %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    void'($urandom(32'h44f2));
    rst_n = 1'b0;
    m_axi_awready = 1'b0;
    m_axi_wready = 1'b0;
    m_axi_bvalid = 1'b0;
    m_axi_bresp = 2'b00;
    mem_req_valid = 1'b0;
    mem_req_bar_hit = 3'd0;
    mem_req_pcie_address = '0;
    mem_req_byte_enable = '0;
    mem_req_write_readn = 1'b0;
    mem_req_phys_func = 1'b0;
    mem_req_write_data = '0;
    repeat (3) @(posedge m_axi_aclk);
    rst_n <= 1'b1;

    for (int b = 0; b < pcie_bridge_pkg::num_bars; b++) begin
      for (int k = 0; k < 4; k++) send_write(b, pcie_bridge_pkg::resp_okay);
    end
    finish_test("bar_mapping_data");

    max_stall = 4;
    for (int k = 0; k < 16; k++) send_write($urandom_range(5, 0), pcie_bridge_pkg::resp_okay);
    finish_test("back_pressure");

    aw_before = aw_count;
    w_before  = w_count;
    drive_req(3'd2, $urandom, 4'hf, 1'b0, $urandom);
    send_write(6, pcie_bridge_pkg::resp_okay);
    send_write(7, pcie_bridge_pkg::resp_okay);
    repeat (6) @(negedge m_axi_aclk);
    checks++;
    if (aw_count != aw_before || w_count != w_before) begin
      errors++;
      $display("ERROR at %0t: AXI traffic seen for a dropped request", $time);
    end
    if (!mem_req_ready) begin
      errors++;
      $display("ERROR at %0t: ready still low after dropped requests", $time);
    end
    finish_test("dropped_requests");

    send_write(1, pcie_bridge_pkg::resp_slverr);
    send_write(4, pcie_bridge_pkg::resp_okay);
    send_write(0, pcie_bridge_pkg::resp_decerr);
    finish_test("slave_error");

    $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Generous per-request budget, stalls included
  initial begin
    #(num_reqs * 40 * clk_period);
    $display("Watchdog expired, the run did not finish in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- vlog.f
source/pcie_bridge_pkg.sv
source/mem_wr_if.sv
source/axi_wr_if.sv
source/mem_req_intake.sv
source/bar_addr_translate.sv
source/axi_write_master.sv
source/pcie_axi_wr_bridge.sv
tests/pcie_axi_wr_bridge_checker.sv
tests/pcie_axi_wr_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; the result is taken from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
  --top-module pcie_axi_wr_bridge_tb -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Testbench passed$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
